// ==== src/noc_pkg.sv ====
/* Mesh router shared types */
`default_nettype none

package noc_pkg;

        localparam int NUM_PORTS = 5;   // N, S, E, W and local.

        // Port order also indexes every per-port array.
        typedef enum logic [2:0] {
                NORTH,
                SOUTH,
                EAST,
                WEST,
                LOCAL
        } port_e;

        typedef logic [NUM_PORTS-1:0] port_vec_t;       // One bit per port.

        typedef logic [3:0] coord_t;                    // One mesh coordinate.
        typedef logic [7:0] payload_t;

        // Own node location, x in the upper nibble.
        typedef struct packed {
                coord_t x;
                coord_t y;
        } node_addr_t;

        // Single-flit packet, sixteen bits.
        typedef struct packed {
                coord_t   dest_x;
                coord_t   dest_y;
                payload_t payload;
        } flit_t;

endpackage

`default_nettype wire

// ==== src/input_fifo.sv ====
/* Input port flit buffer */
`timescale 1ns/10ps
`default_nettype none

module input_fifo
        import noc_pkg::*;
#(
        parameter int FIFO_DEPTH = 4
) (
        input  wire logic  clk,
        input  wire logic  reset_i,
        input  wire logic  push_i,
        input  wire flit_t flit_i,
        input  wire logic  pop_i,
        output flit_t      head_o,
        output logic       nonempty_o
);

        localparam int PTR_W = $clog2(FIFO_DEPTH);
        localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

        typedef logic [PTR_W-1:0] fifo_ptr_t;
        typedef logic [CNT_W-1:0] fifo_cnt_t;

        flit_t     mem [FIFO_DEPTH];
        fifo_ptr_t rd_ptr;
        fifo_ptr_t wr_ptr;
        fifo_cnt_t count;
        logic      full;

        // Wraps at the depth, which need not be a power of two.
        function automatic fifo_ptr_t ptr_next(input fifo_ptr_t ptr);
                return (ptr == fifo_ptr_t'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
        endfunction

        assign full       = (count == fifo_cnt_t'(FIFO_DEPTH));
        assign nonempty_o = (count != '0);
        assign head_o     = mem[rd_ptr];        // Head is visible the cycle after the push.

        always_ff @(posedge clk) begin
                if (push_i) begin
                        mem[wr_ptr] <= flit_i;
                end
        end

        always_ff @(posedge clk) begin
                if (reset_i) begin
                        rd_ptr <= '0;
                        wr_ptr <= '0;
                        count  <= '0;
                end else begin
                        if (push_i)
                                wr_ptr <= ptr_next(wr_ptr);
                        if (pop_i)
                                rd_ptr <= ptr_next(rd_ptr);
                        case ({push_i, pop_i})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;        // Push and pop cancel.
                        endcase
                end
        end

        // Upstream only sends with a credit, so a full buffer never sees a push.
        a_no_push_full: assert property (@(posedge clk) disable iff (reset_i)
                !(push_i && full))
                else $error("input_fifo: push into full buffer");

        a_no_pop_empty: assert property (@(posedge clk) disable iff (reset_i)
                pop_i |-> nonempty_o)
                else $error("input_fifo: pop from empty buffer");

endmodule

`default_nettype wire

// ==== src/route_compute.sv ====
/* XY route computation */
`timescale 1ns/10ps
`default_nettype none

module route_compute
        import noc_pkg::*;
(
        input  wire flit_t      head_i,
        input  wire node_addr_t location_i,
        output port_e           out_port_o
);

        logic x_greater;
        logic x_less;
        logic y_greater;
        logic y_less;

        // Coordinates are unsigned, origin at the south-west corner.
        assign x_greater = (head_i.dest_x > location_i.x);
        assign x_less    = (head_i.dest_x < location_i.x);
        assign y_greater = (head_i.dest_y > location_i.y);
        assign y_less    = (head_i.dest_y < location_i.y);

        // X is resolved fully before Y, which keeps the mesh deadlock free.
        always_comb begin
                if (x_greater)
                        out_port_o = EAST;
                else if (x_less)
                        out_port_o = WEST;
                else if (y_greater)
                        out_port_o = NORTH;
                else if (y_less)
                        out_port_o = SOUTH;
                else
                        out_port_o = LOCAL;     // Arrived at this node.
        end

endmodule

`default_nettype wire

// ==== src/credit_counter.sv ====
/* Output credit counters */
`timescale 1ns/10ps
`default_nettype none

module credit_counter
        import noc_pkg::*;
#(
        parameter int FIFO_DEPTH = 4
) (
        input  wire logic      clk,
        input  wire logic      reset_i,
        input  wire port_vec_t send_i,
        input  wire port_vec_t credit_i,
        output port_vec_t      credit_avail_o
);

        localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

        typedef logic [CNT_W-1:0] credit_cnt_t;

        credit_cnt_t count [NUM_PORTS];         // Free slots downstream.

        for (genvar o = 0; o < NUM_PORTS; o++) begin : g_out
                always_ff @(posedge clk) begin
                        if (reset_i) begin
                                count[o] <= credit_cnt_t'(FIFO_DEPTH);  // Neighbour buffer empty.
                        end else begin
                                case ({send_i[o], credit_i[o]})
                                        2'b10:   count[o] <= count[o] - 1'b1;
                                        2'b01:   count[o] <= count[o] + 1'b1;
                                        default: count[o] <= count[o];
                                endcase
                        end
                end

                assign credit_avail_o[o] = (count[o] != '0);

                // The allocator must hold back any output without credit.
                a_no_send_empty: assert property (@(posedge clk) disable iff (reset_i)
                        send_i[o] |-> (count[o] != '0))
                        else $error("credit_counter: send on port %0d with no credit", o);

                // Downstream never returns more credits than it has slots.
                a_count_bound: assert property (@(posedge clk) disable iff (reset_i)
                        count[o] <= credit_cnt_t'(FIFO_DEPTH))
                        else $error("credit_counter: count above depth on port %0d", o);
        end

endmodule

`default_nettype wire

// ==== src/switch_alloc.sv ====
/* Round-robin switch allocator */
`timescale 1ns/10ps
`default_nettype none

module switch_alloc
        import noc_pkg::*;
(
        input  wire logic      clk,
        input  wire logic      reset_i,
        input  wire port_vec_t nonempty_i,
        input  wire port_e     out_port_i [NUM_PORTS],
        input  wire port_vec_t credit_avail_i,
        output port_vec_t      grant_o [NUM_PORTS],     // Indexed by output, one bit per input.
        output port_vec_t      send_o,
        output port_vec_t      pop_o
);

        // First requester at or after the pointer, wrapping around.
        function automatic port_vec_t rr_pick(input port_vec_t req, input port_e ptr);
                port_vec_t pick;
                logic      found;
                int        idx;
                pick  = '0;
                found = 1'b0;
                for (int k = 0; k < NUM_PORTS; k++) begin
                        idx = int'(ptr) + k;
                        if (idx >= NUM_PORTS)
                                idx = idx - NUM_PORTS;
                        if (!found && req[idx]) begin
                                pick[idx] = 1'b1;
                                found     = 1'b1;
                        end
                end
                return pick;
        endfunction

        // Input after the winner; LOCAL wraps back to NORTH.
        function automatic port_e rr_next(input port_vec_t grant);
                port_e nxt;
                nxt = NORTH;
                for (int i = 0; i < NUM_PORTS - 1; i++) begin
                        if (grant[i])
                                nxt = port_e'(i + 1);
                end
                return nxt;
        endfunction

        for (genvar o = 0; o < NUM_PORTS; o++) begin : g_out
                port_vec_t req;
                port_e     rr_ptr;

                always_comb begin
                        for (int i = 0; i < NUM_PORTS; i++) begin
                                req[i] = nonempty_i[i] && (out_port_i[i] == port_e'(o));
                        end
                end

                // No grant at all while the downstream buffer is full.
                assign grant_o[o] = credit_avail_i[o] ? rr_pick(req, rr_ptr) : '0;

                always_ff @(posedge clk) begin
                        if (reset_i)
                                rr_ptr <= NORTH;
                        else if (grant_o[o] != '0)
                                rr_ptr <= rr_next(grant_o[o]);
                end

                a_grant_onehot: assert property (@(posedge clk) disable iff (reset_i)
                        $onehot0(grant_o[o]))
                        else $error("switch_alloc: multiple grants on output %0d", o);
        end

        // An input requests one output only, so a pop never comes from two grants.
        always_comb begin
                pop_o = '0;
                for (int o = 0; o < NUM_PORTS; o++) begin
                        send_o[o] = |grant_o[o];
                        pop_o     = pop_o | grant_o[o];
                end
        end

endmodule

`default_nettype wire

// ==== src/crossbar.sv ====
/* Registered 5x5 crossbar */
`timescale 1ns/10ps
`default_nettype none

module crossbar
        import noc_pkg::*;
(
        input  wire logic      clk,
        input  wire logic      reset_i,
        input  wire flit_t     head_i [NUM_PORTS],
        input  wire port_vec_t grant_i [NUM_PORTS],
        output flit_t          flit_o [NUM_PORTS],
        output port_vec_t      valid_o
);

        flit_t sel [NUM_PORTS];

        // AND-OR mux, the grant of each output is one-hot.
        always_comb begin
                for (int o = 0; o < NUM_PORTS; o++) begin
                        sel[o] = '0;
                        for (int i = 0; i < NUM_PORTS; i++) begin
                                if (grant_i[o][i])
                                        sel[o] = sel[o] | head_i[i];
                        end
                end
        end

        // Data register only loads on a grant.
        always_ff @(posedge clk) begin
                for (int o = 0; o < NUM_PORTS; o++) begin
                        if (grant_i[o] != '0)
                                flit_o[o] <= sel[o];
                end
        end

        always_ff @(posedge clk) begin
                if (reset_i) begin
                        valid_o <= '0;
                end else begin
                        for (int o = 0; o < NUM_PORTS; o++) begin
                                valid_o[o] <= |grant_i[o];      // Flit goes out next cycle.
                        end
                end
        end

endmodule

`default_nettype wire

// ==== src/router.sv ====
/* Mesh NoC router top */
`timescale 1ns/10ps
`default_nettype none

module router
        import noc_pkg::*;
#(
        parameter int FIFO_DEPTH = 4
) (
        input  wire logic       clk,
        input  wire logic       reset_i,
        input  wire node_addr_t location_i,

        input  wire flit_t      flit_i [NUM_PORTS],
        input  wire port_vec_t  valid_i,
        output port_vec_t       credit_o,

        output flit_t           flit_o [NUM_PORTS],
        output port_vec_t       valid_o,
        input  wire port_vec_t  credit_i
);

        flit_t     head [NUM_PORTS];            // Buffer heads.
        port_vec_t nonempty;
        port_e     out_port [NUM_PORTS];        // Requested output per input.
        port_vec_t credit_avail;
        port_vec_t grant [NUM_PORTS];
        port_vec_t send;
        port_vec_t pop;

        // Input side, buffer and route per port.
        for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
                input_fifo #(
                        .FIFO_DEPTH (FIFO_DEPTH)
                ) u_fifo (
                        .clk        (clk),
                        .reset_i    (reset_i),
                        .push_i     (valid_i[p]),
                        .flit_i     (flit_i[p]),
                        .pop_i      (pop[p]),
                        .head_o     (head[p]),
                        .nonempty_o (nonempty[p])
                );

                route_compute u_route (
                        .head_i     (head[p]),
                        .location_i (location_i),
                        .out_port_o (out_port[p])
                );
        end

        credit_counter #(
                .FIFO_DEPTH (FIFO_DEPTH)
        ) u_credit (
                .clk            (clk),
                .reset_i        (reset_i),
                .send_i         (send),
                .credit_i       (credit_i),
                .credit_avail_o (credit_avail)
        );

        switch_alloc u_alloc (
                .clk            (clk),
                .reset_i        (reset_i),
                .nonempty_i     (nonempty),
                .out_port_i     (out_port),
                .credit_avail_i (credit_avail),
                .grant_o        (grant),
                .send_o         (send),
                .pop_o          (pop)
        );

        crossbar u_xbar (
                .clk     (clk),
                .reset_i (reset_i),
                .head_i  (head),
                .grant_i (grant),
                .flit_o  (flit_o),
                .valid_o (valid_o)
        );

        assign credit_o = pop;  // One credit upstream per popped flit.

endmodule

`default_nettype wire

// ==== tb/router_model.svh ====
/* Router reference model */
`ifndef ROUTER_MODEL_SVH
`define ROUTER_MODEL_SVH

flit_t exp_q [NUM_PORTS][NUM_PORTS][$];         // Expected flits by input and output.
flit_t tx_q [NUM_PORTS][$];                     // Flits still to be sent per input.
int    up_credit [NUM_PORTS];                   // Credits held toward each input.
int    down_owed [NUM_PORTS];                   // Credits owed back on each output.
int    sent_cnt [NUM_PORTS];
int    credit_rx [NUM_PORTS];                   // credit_o pulses per input.
int    recv_cnt [NUM_PORTS];
int    seq_num [NUM_PORTS];

// Dimension order, X first, then Y.
function automatic int xy_port(input flit_t f, input node_addr_t loc);
        if (f.dest_x > loc.x)
                return int'(EAST);
        if (f.dest_x < loc.x)
                return int'(WEST);
        if (f.dest_y > loc.y)
                return int'(NORTH);
        if (f.dest_y < loc.y)
                return int'(SOUTH);
        return int'(LOCAL);
endfunction

// Nothing queued, in flight or owed.
function automatic bit drained();
        for (int p = 0; p < NUM_PORTS; p++) begin
                if (tx_q[p].size() != 0 || down_owed[p] != 0)
                        return 1'b0;
                for (int o = 0; o < NUM_PORTS; o++) begin
                        if (exp_q[p][o].size() != 0)
                                return 1'b0;
                end
        end
        return 1'b1;
endfunction

`endif

// ==== tb/router_tb.sv ====
/* Router testbench */
`timescale 1ns/10ps
`default_nettype none

module router_tb
        import noc_pkg::*;
();

        localparam int         FIFO_DEPTH   = 4;
        localparam int         RESET_CYCLES = 8;
        localparam int         SEED         = 1233;
        localparam node_addr_t LOCATION     = '{x: 4'd2, y: 4'd2};
        localparam int         RANDOM_FLITS = 400;
        localparam int         BP_EAST      = 10;
        localparam int         BP_NORTH     = 6;
        localparam int         CONT_FLITS   = 6;        // Per non-local input.
        localparam int         TOTAL_FLITS  = 1 + RANDOM_FLITS + BP_EAST + BP_NORTH
                                              + 4 * CONT_FLITS;
        localparam int         CYCLE_LIMIT  = TOTAL_FLITS * 20 + 200;

        logic      clk;
        logic      reset_i;
        flit_t     flit_i [NUM_PORTS];
        port_vec_t valid_i;
        port_vec_t credit_o;
        flit_t     flit_o [NUM_PORTS];
        port_vec_t valid_o;
        port_vec_t credit_i;

        port_vec_t hold;                                // Outputs with credits withheld.
        int        cycles;
        int        errors;
        int        recv_total;
        int        tests_passed;
        int        tests_failed;

        `include "router_model.svh"

        router #(
                .FIFO_DEPTH (FIFO_DEPTH)
        ) dut_i (
                .clk        (clk),
                .reset_i    (reset_i),
                .location_i (LOCATION),
                .flit_i     (flit_i),
                .valid_i    (valid_i),
                .credit_o   (credit_o),
                .flit_o     (flit_o),
                .valid_o    (valid_o),
                .credit_i   (credit_i)
        );

        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        // Ends a run whose traffic never drains.
        initial begin
                wait (cycles >= CYCLE_LIMIT);
                @(posedge clk);
                $display("Timeout: traffic did not drain within %0d cycles", CYCLE_LIMIT);
                $display("Testbench failed");
                $finish;
        end

        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
                if (got !== exp) begin
                        $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
                        errors++;
                end
        endtask

        task automatic queue_flit(input int src, input int dx, input int dy);
                flit_t f;
                f.dest_x  = coord_t'(dx);
                f.dest_y  = coord_t'(dy);
                f.payload = {3'(src), 5'(seq_num[src])};       // Source tag and sequence.
                seq_num[src]++;
                tx_q[src].push_back(f);
        endtask

        // Send only while holding an upstream credit.
        task automatic drive_inputs();
                flit_t f;
                for (int p = 0; p < NUM_PORTS; p++) begin
                        if (tx_q[p].size() != 0 && up_credit[p] > 0) begin
                                f = tx_q[p].pop_front();
                                flit_i[p]  <= f;
                                valid_i[p] <= 1'b1;
                                up_credit[p]--;
                                sent_cnt[p]++;
                                exp_q[p][xy_port(f, LOCATION)].push_back(f);
                        end else begin
                                valid_i[p] <= 1'b0;
                        end
                end
        endtask

        task automatic return_credits();
                for (int o = 0; o < NUM_PORTS; o++) begin
                        if (!hold[o] && down_owed[o] > 0 && $urandom_range(0, 1) == 1) begin
                                credit_i[o] <= 1'b1;    // Downstream frees a slot.
                                down_owed[o]--;
                        end else begin
                                credit_i[o] <= 1'b0;
                        end
                end
        endtask

        task automatic observe_outputs();
                int src;
                for (int o = 0; o < NUM_PORTS; o++) begin
                        if (valid_o[o]) begin
                                src = int'(flit_o[o].payload[7:5]);
                                recv_cnt[o]++;
                                recv_total++;
                                down_owed[o]++;
                                if (src >= NUM_PORTS || exp_q[src][o].size() == 0) begin
                                        $display("Output %0d delivered unexpected flit 0x%h",
                                                 o, flit_o[o]);
                                        errors++;
                                end else begin
                                        check_value($sformatf("flit_o[%0d]", o), 32'(flit_o[o]),
                                                    32'(exp_q[src][o].pop_front()));
                                end
                        end
                        if (credit_o[o]) begin
                                up_credit[o]++;
                                credit_rx[o]++;
                        end
                end
        endtask

        // Drive at the rising edge, observe at the falling edge.
        task automatic tick();
                @(posedge clk);
                drive_inputs();
                return_credits();
                @(negedge clk);
                observe_outputs();
                cycles++;
        endtask

        task automatic wait_drained();
                while (!drained()) begin
                        tick();
                end
        endtask

        task automatic finish_test(input string name, input int errors_before);
                if (errors == errors_before) begin
                        tests_passed++;
                        $display("PASS %s", name);
                end else begin
                        tests_failed++;
                        $display("FAIL %s with %0d errors", name, errors - errors_before);
                end
        endtask

        initial begin
                flit_t f;
                int    e0;
                int    base;
                int    base2;
                int    src;
                int    dx;
                int    dy;
                void'($urandom(SEED));
                reset_i  <= 1'b1;
                valid_i  <= '0;
                credit_i <= '0;
                hold = '0;
                cycles = 0;
                errors = 0;
                recv_total = 0;
                tests_passed = 0;
                tests_failed = 0;
                for (int p = 0; p < NUM_PORTS; p++) begin
                        flit_i[p] <= '0;
                        up_credit[p] = FIFO_DEPTH;
                        down_owed[p] = 0;
                        sent_cnt[p] = 0;
                        credit_rx[p] = 0;
                        recv_cnt[p] = 0;
                        seq_num[p] = 0;
                end
                repeat (RESET_CYCLES) @(posedge clk);
                reset_i <= 1'b0;

                e0 = errors;
                repeat (10) begin
                        tick();
                        check_value("valid_o", 32'(valid_o), 32'h0);
                        check_value("credit_o", 32'(credit_o), 32'h0);
                end
                finish_test("reset", e0);

                e0 = errors;
                queue_flit(int'(SOUTH), 2, 4);                  // Routed NORTH.
                f = tx_q[SOUTH][0];
                tick();
                base = 1;
                while (!valid_o[NORTH] && base < 10) begin
                        tick();
                        base++;
                end
                check_value("latency", 32'(base), 32'd3);       // One edge to sample, two to the output.
                check_value("flit_o[NORTH]", 32'(flit_o[NORTH]), 32'(f));
                wait_drained();
                finish_test("latency", e0);

                e0 = errors;
                base = recv_total;
                for (int n = 0; n < RANDOM_FLITS; n++) begin
                        src = $urandom_range(0, NUM_PORTS - 1);
                        dx  = $urandom_range(0, 4);
                        dy  = $urandom_range(0, 4);
                        queue_flit(src, dx, dy);
                end
                wait_drained();
                check_value("flits delivered", 32'(recv_total - base), 32'(RANDOM_FLITS));
                finish_test("routing and delivery", e0);

                e0 = errors;
                for (int p = 0; p < NUM_PORTS; p++) begin
                        check_value($sformatf("credit_o[%0d] pulses", p), 32'(credit_rx[p]),
                                    32'(sent_cnt[p]));
                        check_value($sformatf("upstream credit %0d", p), 32'(up_credit[p]),
                                    32'(FIFO_DEPTH));
                end
                finish_test("credit return", e0);

                e0 = errors;
                hold[EAST] = 1'b1;
                base  = recv_cnt[EAST];
                base2 = recv_cnt[NORTH];
                for (int n = 0; n < BP_EAST; n++)
                        queue_flit(int'(WEST), 4, 2);
                for (int n = 0; n < BP_NORTH; n++)
                        queue_flit(int'(LOCAL), 2, 4);
                while (recv_cnt[EAST] - base < FIFO_DEPTH
                       || recv_cnt[NORTH] - base2 < BP_NORTH) begin
                        tick();
                end
                repeat (20) tick();                             // A flit past the credits shows here.
                check_value("EAST flits while held", 32'(recv_cnt[EAST] - base), 32'(FIFO_DEPTH));
                hold[EAST] = 1'b0;
                wait_drained();
                check_value("EAST flits after release", 32'(recv_cnt[EAST] - base), 32'(BP_EAST));
                finish_test("back-pressure", e0);

                e0 = errors;
                base = recv_cnt[LOCAL];
                for (int n = 0; n < CONT_FLITS; n++) begin
                        for (int p = 0; p < 4; p++)
                                queue_flit(p, 2, 2);            // All four neighbours to LOCAL.
                end
                wait_drained();
                check_value("LOCAL flits", 32'(recv_cnt[LOCAL] - base), 32'(4 * CONT_FLITS));
                finish_test("contention", e0);

                $display("Tests passed %0d, failed %0d", tests_passed, tests_failed);
                if (tests_failed == 0)
                        $display("Testbench passed");
                else
                        $display("Testbench failed");
                $finish;
        end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+tb
src/noc_pkg.sv
src/input_fifo.sv
src/route_compute.sv
src/credit_counter.sv
src/switch_alloc.sv
src/crossbar.sv
src/router.sv
tb/router_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= router_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulation prints the pass line.
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)
